/* include/lsu_consts.svh */
// shared lsu constants; the data path is written for 32-bit words and at most two transactions in flight
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

////////////////////
// widths
////////////////////

`define LSU_XLEN   32  // address and data width
`define LSU_NBYTES 4   // bytes per word

// outstanding bus transactions the lsu keeps in flight
`define LSU_DEPTH  2

////////////////////
// access size codes, 2'b11 is treated as byte as well
////////////////////

`define LSU_TYPE_WORD 2'b00
`define LSU_TYPE_HALF 2'b01
`define LSU_TYPE_BYTE 2'b10

// extension modes, every code other than these two sign-extends
`define LSU_EXT_ZERO  2'b00
`define LSU_EXT_ONES  2'b10

`endif

/* design/lsu_types_pkg.sv */
// data-path types of the lsu; struct field order is fixed and must match the ex stage packing
`default_nettype none

`include "lsu_consts.svh"

package lsu_types_pkg;

  ////////////////////
  // plain vectors
  ////////////////////

  typedef logic [`LSU_XLEN-1:0]             word_t;      // address or data word
  typedef logic [`LSU_NBYTES-1:0]           byte_en_t;   // one bit per byte lane
  typedef logic [$clog2(`LSU_NBYTES)-1:0]   byte_off_t;  // byte position inside a word
  typedef logic [1:0]                       data_type_t; // word / half / byte
  typedef logic [1:0]                       sign_ext_t;  // zero, ones or sign fill
  typedef logic [$clog2(`LSU_DEPTH+1)-1:0]  cnt_t;       // holds 0..depth

  // request as presented by the ex stage, 104 bits
  typedef struct packed {
    logic       we;          // store when set
    data_type_t data_type;
    sign_ext_t  sign_ext;
    byte_off_t  reg_offset;  // byte offset of the store data inside rs2
    word_t      wdata;
    word_t      operand_a;   // base address
    word_t      operand_b;   // offset, only with use_incr
    logic       use_incr;
  } lsu_ex_req_t;

  // what wb needs to align the response, 7 bits
  typedef struct packed {
    data_type_t data_type;
    sign_ext_t  sign_ext;
    byte_off_t  rdata_offset;
    logic       we;
  } load_ctrl_t;

endpackage

`default_nettype wire

/* design/lsu_bus_pkg.sv */
// data bus structs; validity comes from the separate req and rvalid strobes, not from the structs
`default_nettype none

package lsu_bus_pkg;

  ////////////////////
  // address phase
  ////////////////////

  // qualified by data_req_o, held stable until data_gnt_i
  typedef struct packed {
    lsu_types_pkg::word_t    addr;   // word aligned in the second phase of a split access
    logic                    we;
    lsu_types_pkg::byte_en_t be;
    lsu_types_pkg::word_t    wdata;  // already rotated onto the byte lanes
  } bus_req_t;

  ////////////////////
  // response phase
  ////////////////////

  // qualified by data_rvalid_i
  // responses come back in request order, at least one cycle after grant
  typedef struct packed {
    lsu_types_pkg::word_t rdata;  // raw word, lane aligned
  } bus_rsp_t;

  // no error field, bus errors are not reported to the core

endpackage

`default_nettype wire

/* design/lsu_store_path.sv */
// purely combinational; assumes the ex stage bumps operand_a by 4 and sets data_misaligned_ex_i for phase two
`default_nettype none

`include "lsu_consts.svh"

module lsu_store_path (
  input  logic                       data_req_ex_i,
  input  lsu_types_pkg::lsu_ex_req_t ex_req_i,
  input  logic                       data_misaligned_ex_i,  // second phase of a split access
  output logic                       data_misaligned_o,     // split needed, to controller
  output lsu_types_pkg::byte_off_t   addr_off_o,
  output lsu_bus_pkg::bus_req_t      bus_fields_o
);

  import lsu_types_pkg::*;

  word_t                  addr_int;   // effective address
  byte_off_t              addr_off;   // low address bits
  byte_off_t              wdata_off;  // lane rotation amount
  byte_en_t               be;
  logic [2*`LSU_XLEN-1:0] wdata_dbl;  // doubled word for the rotate

  ////////////////////
  // address
  ////////////////////

  assign addr_int = ex_req_i.use_incr ? (ex_req_i.operand_a + ex_req_i.operand_b)
                                      : ex_req_i.operand_a;
  assign addr_off = addr_int[1:0];

  // the load path keeps the unaligned offset for both phases
  assign addr_off_o = addr_off;

  ////////////////////
  // split detection
  ////////////////////

  // only the first phase can ask for a second access
  always_comb begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i) begin
      case (ex_req_i.data_type)
        `LSU_TYPE_WORD: data_misaligned_o = (addr_off != 2'd0);  // any offset crosses
        `LSU_TYPE_HALF: data_misaligned_o = (addr_off == 2'd3);  // top lane only
        default:        data_misaligned_o = 1'b0;                // bytes never cross
      endcase
    end
  end

  ////////////////////
  // byte enables
  ////////////////////

  always_comb begin
    case (ex_req_i.data_type)
      `LSU_TYPE_WORD: begin
        if (!data_misaligned_ex_i) begin
          be = 4'b1111 << addr_off;     // upper lanes of the first word
        end else begin
          be = ~(4'b1111 << addr_off);  // remaining low lanes of the next word
        end
      end
      `LSU_TYPE_HALF: begin
        if (!data_misaligned_ex_i) begin
          be = 4'b0011 << addr_off;     // offset 3 drops the upper byte here
        end else begin
          be = 4'b0001;                 // that byte lands in lane 0
        end
      end
      default: be = 4'b0001 << addr_off;
    endcase
  end

  ////////////////////
  // write data
  ////////////////////

  // rotate left by whole bytes so the register byte lands in the address lane
  assign wdata_off = addr_off - ex_req_i.reg_offset;  // wraps mod 4
  assign wdata_dbl = {ex_req_i.wdata, ex_req_i.wdata} << {wdata_off, 3'b000};

  ////////////////////
  // address phase fields
  ////////////////////

  assign bus_fields_o.addr  = data_misaligned_ex_i ? {addr_int[`LSU_XLEN-1:2], 2'b00}
                                                   : addr_int;
  assign bus_fields_o.we    = ex_req_i.we;
  assign bus_fields_o.be    = be;
  assign bus_fields_o.wdata = wdata_dbl[2*`LSU_XLEN-1:`LSU_XLEN];  // upper half is the rotation

endmodule

`default_nettype wire

/* design/lsu_load_path.sv */
// wb-side alignment; a split load relies on the ex stage presenting phase two when phase one answers
`default_nettype none

`include "lsu_consts.svh"

module lsu_load_path (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ctrl_update_i,         // request moves on to wb
  input  logic                       data_rvalid_i,
  input  lsu_types_pkg::lsu_ex_req_t ex_req_i,
  input  lsu_types_pkg::byte_off_t   addr_off_i,
  input  logic                       data_misaligned_ex_i,  // ex is in phase two
  input  logic                       data_misaligned_i,     // ex starts a split
  input  lsu_bus_pkg::bus_rsp_t      bus_rsp_i,
  output lsu_types_pkg::word_t       data_rdata_ex_o
);

  import lsu_types_pkg::*;

  load_ctrl_t  ctrl_q;     // control of the access now in wb
  word_t       rdata_q;    // raw first half of a split, or last result
  word_t       rsp;
  word_t       rdata_w;    // word, possibly assembled from two responses
  word_t       rdata_h;
  word_t       rdata_b;
  word_t       rdata_ext;  // selected and extended result
  logic [15:0] half_raw;
  logic [7:0]  byte_raw;

  // fill the bits outside keep_mask by the extension mode
  function automatic word_t extend(input word_t raw, input logic msb, input word_t keep_mask,
                                   input sign_ext_t mode);
    word_t fill;
    case (mode)
      `LSU_EXT_ZERO: fill = '0;
      `LSU_EXT_ONES: fill = '1;
      default:       fill = {`LSU_XLEN{msb}};  // sign
    endcase
    extend = (raw & keep_mask) | (fill & ~keep_mask);
  endfunction

  ////////////////////
  // wb control
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '0;
    end else if (ctrl_update_i) begin
      ctrl_q.data_type    <= ex_req_i.data_type;
      ctrl_q.sign_ext     <= ex_req_i.sign_ext;
      ctrl_q.rdata_offset <= addr_off_i;  // same low bits in both phases
      ctrl_q.we           <= ex_req_i.we;
    end
  end

  assign rsp = bus_rsp_i.rdata;

  ////////////////////
  // lane selection
  ////////////////////

  // word; nonzero offset only happens in phase two, low bytes come from the hold reg
  always_comb begin
    case (ctrl_q.rdata_offset)
      2'd1:    rdata_w = {rsp[7:0],  rdata_q[31:8]};
      2'd2:    rdata_w = {rsp[15:0], rdata_q[31:16]};
      2'd3:    rdata_w = {rsp[23:0], rdata_q[31:24]};
      default: rdata_w = rsp;
    endcase
  end

  // halfword at offset 3 spans two responses
  always_comb begin
    if (ctrl_q.rdata_offset == 2'd3) begin
      half_raw = {rsp[7:0], rdata_q[31:24]};
    end else begin
      half_raw = rsp[{ctrl_q.rdata_offset, 3'b000} +: 16];
    end
  end

  assign byte_raw = rsp[{ctrl_q.rdata_offset, 3'b000} +: 8];

  assign rdata_h = extend({16'h0000, half_raw}, half_raw[15], 32'h0000_ffff, ctrl_q.sign_ext);
  assign rdata_b = extend({24'h00_0000, byte_raw}, byte_raw[7], 32'h0000_00ff, ctrl_q.sign_ext);

  always_comb begin
    case (ctrl_q.data_type)
      `LSU_TYPE_WORD: rdata_ext = rdata_w;
      `LSU_TYPE_HALF: rdata_ext = rdata_h;
      default:        rdata_ext = rdata_b;  // 10 and 11
    endcase
  end

  ////////////////////
  // hold register
  ////////////////////

  // a split in progress keeps the raw word for assembly, otherwise the final value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (data_rvalid_i && !ctrl_q.we) begin
      if (data_misaligned_ex_i || data_misaligned_i) begin
        rdata_q <= rsp;
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  // live result in the response cycle, held value in between
  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;

endmodule

`default_nettype wire

/* design/lsu_txn_tracker.sv */
// assumes every grant gets exactly one in-order rvalid at least one cycle later and a stable request
`default_nettype none

`include "lsu_consts.svh"

module lsu_txn_tracker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  data_req_ex_i,
  input  lsu_bus_pkg::bus_req_t bus_fields_i,
  input  logic                  data_gnt_i,
  input  logic                  data_rvalid_i,
  output logic                  data_req_o,
  output lsu_bus_pkg::bus_req_t bus_req_o,
  output logic                  lsu_ready_ex_o,
  output logic                  lsu_ready_wb_o,
  output logic                  busy_o,
  output logic                  ctrl_update_o   // ex request moves to wb
);

  import lsu_types_pkg::*;

  localparam cnt_t DEPTH = cnt_t'(`LSU_DEPTH);

  cnt_t cnt_q;        // outstanding transactions
  cnt_t cnt_d;
  logic trans_valid;  // request allowed onto the bus
  logic count_up;
  logic count_down;

  ////////////////////
  // request side
  ////////////////////

  // no path from rvalid to req, a full tracker simply holds off
  assign trans_valid = data_req_ex_i && (cnt_q < DEPTH);
  assign data_req_o  = trans_valid;
  assign bus_req_o   = bus_fields_i;  // address phase straight from the ex stage

  // busy also covers the cycle a request is first raised
  assign busy_o = (cnt_q != '0) || trans_valid;

  ////////////////////
  // ready signals
  ////////////////////

  // wb is free when empty, else it frees up with the awaited response
  assign lsu_ready_wb_o = (cnt_q == '0) ? 1'b1 : data_rvalid_i;

  // ex and wb advance in lock step once wb holds something
  always_comb begin
    if (!data_req_ex_i) begin
      lsu_ready_ex_o = 1'b1;                        // nothing to do
    end else if (cnt_q == '0) begin
      lsu_ready_ex_o = trans_valid && data_gnt_i;   // wb empty, grant is enough
    end else if (cnt_q < DEPTH) begin
      lsu_ready_ex_o = data_rvalid_i && trans_valid && data_gnt_i;
    end else begin
      lsu_ready_ex_o = data_rvalid_i;               // already issued, wait for wb
    end
  end

  assign ctrl_update_o = lsu_ready_ex_o && data_req_ex_i;

  ////////////////////
  // counter
  ////////////////////

  assign count_up   = trans_valid && data_gnt_i;
  assign count_down = data_rvalid_i;

  always_comb begin
    case ({count_up, count_down})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q;  // none, or one in and one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // the gating must keep the count within depth across any grant pattern
  a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n) cnt_q <= DEPTH)
    else $error("outstanding count above depth");

  // the bus must not answer a request that was never granted
  a_no_spurious_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> (cnt_q != '0))
    else $error("rvalid with no transaction outstanding");

endmodule

`default_nettype wire

/* design/lsu_top.sv */
// lsu top level; the ex stage owns split sequencing and must hold its request until lsu_ready_ex_o
`default_nettype none

module lsu_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // ex stage
  input  logic                       data_req_ex_i,
  input  lsu_types_pkg::lsu_ex_req_t ex_req_i,
  input  logic                       data_misaligned_ex_i,
  output logic                       data_misaligned_o,
  output logic                       lsu_ready_ex_o,
  output logic                       lsu_ready_wb_o,
  output logic                       busy_o,
  output lsu_types_pkg::word_t       data_rdata_ex_o,

  // data bus
  output logic                       data_req_o,
  output lsu_bus_pkg::bus_req_t      bus_req_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  lsu_bus_pkg::bus_rsp_t      bus_rsp_i
);

  import lsu_types_pkg::*;
  import lsu_bus_pkg::*;

  byte_off_t addr_off;     // unaligned low address bits
  bus_req_t  bus_fields;   // address phase before gating
  logic      ctrl_update;  // wb control load

  // address, enables, write data
  lsu_store_path u_store_path (
    .data_req_ex_i       (data_req_ex_i),
    .ex_req_i            (ex_req_i),
    .data_misaligned_ex_i(data_misaligned_ex_i),
    .data_misaligned_o   (data_misaligned_o),
    .addr_off_o          (addr_off),
    .bus_fields_o        (bus_fields)
  );

  // outstanding count and handshakes
  lsu_txn_tracker u_txn_tracker (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_req_ex_i (data_req_ex_i),
    .bus_fields_i  (bus_fields),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_req_o    (data_req_o),
    .bus_req_o     (bus_req_o),
    .lsu_ready_ex_o(lsu_ready_ex_o),
    .lsu_ready_wb_o(lsu_ready_wb_o),
    .busy_o        (busy_o),
    .ctrl_update_o (ctrl_update)
  );

  // response alignment, rvalid is the response strobe
  lsu_load_path u_load_path (
    .clk                 (clk),
    .rst_n               (rst_n),
    .ctrl_update_i       (ctrl_update),
    .data_rvalid_i       (data_rvalid_i),
    .ex_req_i            (ex_req_i),
    .addr_off_i          (addr_off),
    .data_misaligned_ex_i(data_misaligned_ex_i),
    .data_misaligned_i   (data_misaligned_o),
    .bus_rsp_i           (bus_rsp_i),
    .data_rdata_ex_o     (data_rdata_ex_o)
  );

endmodule

`default_nettype wire

/* tests/lsu_mem_model.sv */
// simulation-only bus slave; 64 words, byte address bits above 7 are ignored, reset reloads the fill
`default_nettype none

module lsu_mem_model (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  data_req_i,
  input  lsu_bus_pkg::bus_req_t bus_req_i,
  output logic                  data_gnt_o,
  output logic                  data_rvalid_o,  // exactly one cycle after each grant
  output lsu_bus_pkg::bus_rsp_t bus_rsp_o
);

  import lsu_bus_pkg::*;

  integer      seed = 32'h230a_ddce;  // grant delay stream
  logic [31:0] mem [0:63];
  logic [5:0]  idx;                   // word index
  logic [1:0]  delay_q;               // cycles to stall the next request
  logic [1:0]  waited_q;              // cycles the current request has waited

  // every byte takes a value from its own byte address
  function automatic logic [31:0] fill_word(input int i);
    logic [31:0] w;
    for (int b = 0; b < 4; b++) begin
      w[8*b +: 8] = 8'(4*i + b) ^ 8'h5a;
    end
    fill_word = w;
  endfunction

  assign idx        = bus_req_i.addr[7:2];
  assign data_gnt_o = data_req_i && (waited_q >= delay_q);  // delay 0 grants at once

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 64; i++) begin
        mem[i] <= fill_word(i);
      end
      delay_q         <= 2'd0;
      waited_q        <= 2'd0;
      data_rvalid_o   <= 1'b0;
      bus_rsp_o.rdata <= '0;
    end else if (data_req_i && data_gnt_o) begin
      if (bus_req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus_req_i.be[b]) begin
            mem[idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];  // enabled lanes only
          end
        end
      end
      bus_rsp_o.rdata <= mem[idx];  // old word on a store, nobody reads it
      data_rvalid_o   <= 1'b1;
      waited_q        <= 2'd0;
      delay_q         <= 2'($unsigned($random(seed)) % 3);
    end else begin
      data_rvalid_o <= 1'b0;
      if (data_req_i) begin
        waited_q <= waited_q + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* tests/lsu_tb.sv */
// table-driven lsu testbench; addresses stay below 0x100 and the bus model answers one cycle after grant
`default_nettype none

`include "lsu_consts.svh"

module lsu_tb;

  import lsu_types_pkg::*;
  import lsu_bus_pkg::*;

  localparam int         CLK_PERIOD = 100;
  localparam int         DRIVE_DLY  = 10;   // input skew after the rising edge
  localparam data_type_t T_W        = `LSU_TYPE_WORD;
  localparam data_type_t T_H        = `LSU_TYPE_HALF;
  localparam data_type_t T_B        = `LSU_TYPE_BYTE;
  localparam sign_ext_t  X_Z        = `LSU_EXT_ZERO;
  localparam sign_ext_t  X_O        = `LSU_EXT_ONES;
  localparam sign_ext_t  X_S        = 2'b01;  // any other code sign-extends

  // one access of the table
  typedef struct packed {
    logic       we;
    data_type_t dtype;
    sign_ext_t  ext;
    word_t      opa;
    word_t      opb;
    byte_off_t  roff;
    word_t      wdata;
    word_t      exp;    // expected load result
  } entry_t;

  logic        clk;
  logic        rst_n;
  logic        data_req_ex;
  lsu_ex_req_t ex_req;
  logic        misaligned_ex;
  logic        data_misaligned;
  logic        lsu_ready_ex;
  logic        lsu_ready_wb;
  logic        busy;
  word_t       data_rdata_ex;
  logic        data_req;
  bus_req_t    bus_req;
  logic        data_gnt;
  logic        data_rvalid;
  bus_rsp_t    bus_rsp;

  entry_t     tbl[$];
  int         kind_q[$];        // 0 no check, 1 table value, 2 table and ref model
  word_t      exp_q[$];
  word_t      ref_q[$];
  logic [7:0] ref_mem [0:255];  // byte-wide reference of the bus memory
  int         n_errors;
  int         n_checks;
  int         outstanding;      // granted, not yet answered
  int         n_grants;         // requests the bus took
  int         n_accepts;        // requests ex saw accepted
  logic       tbl_ready;

  lsu_top lsu_top_i (
    .clk                 (clk),
    .rst_n               (rst_n),
    .data_req_ex_i       (data_req_ex),
    .ex_req_i            (ex_req),
    .data_misaligned_ex_i(misaligned_ex),
    .data_misaligned_o   (data_misaligned),
    .lsu_ready_ex_o      (lsu_ready_ex),
    .lsu_ready_wb_o      (lsu_ready_wb),
    .busy_o              (busy),
    .data_rdata_ex_o     (data_rdata_ex),
    .data_req_o          (data_req),
    .bus_req_o           (bus_req),
    .data_gnt_i          (data_gnt),
    .data_rvalid_i       (data_rvalid),
    .bus_rsp_i           (bus_rsp)
  );

  lsu_mem_model u_mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .data_req_i   (data_req),
    .bus_req_i    (bus_req),
    .data_gnt_o   (data_gnt),
    .data_rvalid_o(data_rvalid),
    .bus_rsp_o    (bus_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic check_value(input string name, input word_t got, input word_t exp_v);
    n_checks++;
    if (got !== exp_v) begin
      n_errors++;
      $display("[FAIL] %s: got %h, expected %h", name, got, exp_v);
    end
  endtask

  function automatic void add_entry(input logic we, input data_type_t dt, input sign_ext_t ext,
                                    input word_t opa, input word_t opb, input byte_off_t roff,
                                    input word_t wdata, input word_t exp_v);
    tbl.push_back(entry_t'{we, dt, ext, opa, opb, roff, wdata, exp_v});
  endfunction

  function automatic word_t eff_addr(input entry_t e);
    eff_addr = e.opa + e.opb;
  endfunction

  // word off a lane boundary, or a halfword in the top lane, takes two accesses
  function automatic logic needs_split(input entry_t e);
    byte_off_t off;
    off = byte_off_t'(eff_addr(e));
    case (e.dtype)
      `LSU_TYPE_WORD: needs_split = (off != 2'd0);
      `LSU_TYPE_HALF: needs_split = (off == 2'd3);
      default:        needs_split = 1'b0;
    endcase
  endfunction

  // little-endian store, register byte roff+k lands at address+k
  function automatic void store_ref(input entry_t e);
    int    n;
    word_t a;
    a = eff_addr(e);
    case (e.dtype)
      `LSU_TYPE_WORD: n = 4;
      `LSU_TYPE_HALF: n = 2;
      default:        n = 1;
    endcase
    for (int k = 0; k < n; k++) begin
      ref_mem[8'(a + k)] = e.wdata[8*((int'(e.roff) + k) % 4) +: 8];
    end
  endfunction

  function automatic word_t ref_word(input word_t a);
    ref_word = {ref_mem[8'(a + 3)], ref_mem[8'(a + 2)], ref_mem[8'(a + 1)], ref_mem[8'(a)]};
  endfunction

  function automatic void push_rsp(input int kind, input word_t exp_v, input word_t ref_v);
    kind_q.push_back(kind);
    exp_q.push_back(exp_v);
    ref_q.push_back(ref_v);
  endfunction

  // present one phase and hold it until the lsu takes it
  task automatic drive_phase(input entry_t e, input logic second);
    ex_req.we         = e.we;
    ex_req.data_type  = e.dtype;
    ex_req.sign_ext   = e.ext;
    ex_req.reg_offset = e.roff;
    ex_req.wdata      = e.wdata;
    ex_req.operand_a  = second ? e.opa + 32'd4 : e.opa;  // next word for phase two
    // a zero offset goes without use_incr, so operand_b carries a value that must be ignored
    ex_req.operand_b  = (e.opb != '0) ? e.opb : 32'h0000_0080;
    ex_req.use_incr   = (e.opb != '0);
    misaligned_ex     = second;
    data_req_ex       = 1'b1;
    @(posedge clk);
    while (!lsu_ready_ex) @(posedge clk);
  endtask

  task automatic build_table();
    // byte and halfword stores into one word, then read back
    add_entry(1'b1, T_W, X_Z, 'h10, 'h0, 2'd0, 'hdead_beef, 'h0);
    add_entry(1'b0, T_W, X_Z, 'h10, 'h0, 2'd0, 'h0, 'hdead_beef);
    add_entry(1'b1, T_B, X_Z, 'h10, 'h1, 2'd0, 'h0000_00aa, 'h0);
    add_entry(1'b1, T_H, X_Z, 'h10, 'h2, 2'd0, 'h0000_1234, 'h0);
    add_entry(1'b1, T_B, X_Z, 'h10, 'h0, 2'd2, 'h0077_0000, 'h0);  // data from rs2 byte 2
    add_entry(1'b0, T_W, X_Z, 'h10, 'h0, 2'd0, 'h0, 'h1234_aa77);
    add_entry(1'b1, T_W, X_Z, 'h30, 'h0, 2'd0, 'h1122_3344, 'h0);
    add_entry(1'b1, T_H, X_Z, 'h30, 'h1, 2'd0, 'h0000_beef, 'h0);
    add_entry(1'b1, T_B, X_Z, 'h30, 'h3, 2'd1, 'h0000_5500, 'h0);  // rs2 byte 1 to the top lane
    add_entry(1'b0, T_W, X_Z, 'h30, 'h0, 2'd0, 'h0, 'h55be_ef44);
    // stores at the remaining offsets take upper rs2 bytes
    add_entry(1'b1, T_H, X_Z, 'h18, 'h0, 2'd2, 'h6789_0000, 'h0);
    add_entry(1'b1, T_B, X_Z, 'h18, 'h2, 2'd3, 'h9900_0000, 'h0);
    add_entry(1'b0, T_W, X_Z, 'h18, 'h0, 2'd0, 'h0, 'h4199_6789);
    // extension modes
    add_entry(1'b1, T_W, X_Z, 'h20, 'h0, 2'd0, 'h80ff_7f01, 'h0);
    add_entry(1'b0, T_B, X_S, 'h20, 'h0, 2'd0, 'h0, 'h0000_0001);
    add_entry(1'b0, T_B, X_Z, 'h20, 'h2, 2'd0, 'h0, 'h0000_00ff);
    add_entry(1'b0, T_B, X_S, 'h22, 'h0, 2'd0, 'h0, 'hffff_ffff);
    add_entry(1'b0, T_B, X_O, 'h20, 'h1, 2'd0, 'h0, 'hffff_ff7f);
    add_entry(1'b0, 2'b11, 2'b11, 'h20, 'h3, 2'd0, 'h0, 'hffff_ff80);  // spare codes
    add_entry(1'b0, T_H, X_S, 'h20, 'h0, 2'd0, 'h0, 'h0000_7f01);
    add_entry(1'b0, T_H, X_Z, 'h21, 'h0, 2'd0, 'h0, 'h0000_ff7f);
    add_entry(1'b0, T_H, X_S, 'h20, 'h2, 2'd0, 'h0, 'hffff_80ff);
    // split loads across 0x40 and 0x44
    add_entry(1'b1, T_W, X_Z, 'h40, 'h0, 2'd0, 'h0302_0100, 'h0);
    add_entry(1'b1, T_W, X_Z, 'h44, 'h0, 2'd0, 'h8786_8584, 'h0);
    add_entry(1'b0, T_W, X_Z, 'h40, 'h1, 2'd0, 'h0, 'h8403_0201);
    add_entry(1'b0, T_W, X_Z, 'h40, 'h2, 2'd0, 'h0, 'h8584_0302);
    add_entry(1'b0, T_W, X_Z, 'h40, 'h3, 2'd0, 'h0, 'h8685_8403);
    add_entry(1'b0, T_H, X_S, 'h40, 'h3, 2'd0, 'h0, 'hffff_8403);
    // split stores, neighbours keep the fill
    add_entry(1'b1, T_W, X_Z, 'h48, 'h2, 2'd0, 'hcafe_f00d, 'h0);
    add_entry(1'b0, T_W, X_Z, 'h48, 'h2, 2'd0, 'h0, 'hcafe_f00d);
    add_entry(1'b0, T_W, X_Z, 'h4c, 'h0, 2'd0, 'h0, 'h1514_cafe);
    add_entry(1'b1, T_H, X_Z, 'h53, 'h0, 2'd0, 'h0000_abcd, 'h0);
    add_entry(1'b0, T_W, X_Z, 'h50, 'h0, 2'd0, 'h0, 'hcd08_0b0a);
    add_entry(1'b0, T_W, X_Z, 'h54, 'h0, 2'd0, 'h0, 'h0d0c_0fab);
  endtask

  ////////////////////
  // response and occupancy monitor
  ////////////////////

  always @(posedge clk) begin : monitor
    int    kind;
    word_t exp_v;
    word_t ref_v;
    if (rst_n) begin
      if (outstanding != 0 && !busy) begin
        n_errors++;
        $display("busy_o is low with %0d transactions outstanding", outstanding);
      end
      // wb is free when idle, or in the cycle the awaited response comes back
      check_value("lsu_ready_wb_o", 32'(lsu_ready_wb), 32'(outstanding == 0 || data_rvalid));
      if (data_rvalid) begin
        if (kind_q.size() == 0) begin
          n_errors++;
          $display("bus response arrived with no request pending");
        end else begin
          kind  = kind_q.pop_front();
          exp_v = exp_q.pop_front();
          ref_v = ref_q.pop_front();
          if (kind != 0) check_value("data_rdata_ex_o", data_rdata_ex, exp_v);
          if (kind == 2) check_value("data_rdata_ex_o vs ref", data_rdata_ex, ref_v);
        end
      end
      n_grants  = n_grants + int'(data_req && data_gnt);
      n_accepts = n_accepts + int'(data_req_ex && lsu_ready_ex);
      if (n_accepts > n_grants) begin
        n_errors++;
        $display("lsu_ready_ex_o released a request that the bus never granted");
      end
      outstanding = outstanding + int'(data_req && data_gnt) - int'(data_rvalid);
      if (outstanding > `LSU_DEPTH) begin
        n_errors++;
        $display("more than %0d requests granted without a response", `LSU_DEPTH);
      end
    end
  end

  // budget of 20 cycles per table entry
  initial begin : watchdog
    wait (tbl_ready);
    repeat (tbl.size() * 20) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", tbl.size() * 20);
    $display("Test failed");
    $finish;
  end

  ////////////////////
  // stimulus
  ////////////////////

  initial begin : main
    entry_t e;
    logic   split;
    rst_n         = 1'b0;
    data_req_ex   = 1'b0;
    ex_req        = '0;
    misaligned_ex = 1'b0;
    n_errors      = 0;
    n_checks      = 0;
    outstanding   = 0;
    n_grants      = 0;
    n_accepts     = 0;
    tbl_ready     = 1'b0;
    for (int a = 0; a < 256; a++) begin
      ref_mem[a] = 8'(a) ^ 8'h5a;  // same fill as the bus model
    end
    build_table();
    tbl_ready = 1'b1;
    repeat (2) @(posedge clk);
    #DRIVE_DLY rst_n = 1'b1;
    @(posedge clk);
    check_value("data_req_o", 32'(data_req), 32'h0);
    check_value("busy_o", 32'(busy), 32'h0);
    check_value("lsu_ready_wb_o", 32'(lsu_ready_wb), 32'h1);
    #DRIVE_DLY;
    foreach (tbl[i]) begin
      e     = tbl[i];
      split = needs_split(e);
      drive_phase(e, 1'b0);
      check_value("data_misaligned_o", 32'(data_misaligned), 32'(split));
      if (split) begin
        push_rsp(0, '0, '0);  // first half, not a result yet
        #DRIVE_DLY;
        drive_phase(e, 1'b1);
      end
      if (e.we) begin
        store_ref(e);
        push_rsp(0, '0, '0);
      end else if (!split && e.dtype == T_W) begin
        push_rsp(2, e.exp, ref_word(eff_addr(e)));
      end else begin
        push_rsp(1, e.exp, '0);
      end
      #DRIVE_DLY;
    end
    data_req_ex   = 1'b0;
    misaligned_ex = 1'b0;
    while (kind_q.size() != 0) @(posedge clk);  // drain the responses
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
design/lsu_types_pkg.sv
design/lsu_bus_pkg.sv
design/lsu_store_path.sv
design/lsu_load_path.sv
design/lsu_txn_tracker.sv
design/lsu_top.sv
tests/lsu_mem_model.sv
tests/lsu_tb.sv
